// ==== dv/fod_ctrl_tb.sv ====
`timescale 1ns/100ps

module fod_ctrl_tb import fod_pkg::*; ();

	localparam int TIMEOUT_CYC = 1200;

	// expected word and the cycle its strobe is due
	typedef struct packed {
		dcw_t word;
		int   due;
	} exp_t;

	// dut ports
	logic             CLK;
	logic             NRST;
	fcw_t             fcw;
	logic             step;
	logic             rt_en;
	logic [DCW_W-1:0] kdtc_init;
	logic             cal_en;
	logic [3:0]       lms_shift;
	phe_t             phe;
	logic             phe_valid;
	dcw_t             dcw;
	logic             dcw_valid;

	// run bookkeeping
	int   seed = 98;
	int   cyc = 0;
	int   checks = 0;
	int   errors = 0;
	int   step_cnt = 0;
	int   valid_cnt = 0;
	int   fixed_gain[4] = '{0, 1, 517, 1023};
	exp_t exp_q[$];
	dcw_t last_dcw = DCW_RESET;
	// reference model state
	logic [WF-1:0] m_acc;
	gain_t         m_gain;
	logic [WF-1:0] m_rem_last;
	logic          m_pend_valid;
	dsm_word_t     m_pend;

	fod_ctrl UUT (
		.CLK       (CLK),
		.NRST      (NRST),
		.fcw       (fcw),
		.step      (step),
		.rt_en     (rt_en),
		.kdtc_init (kdtc_init),
		.cal_en    (cal_en),
		.lms_shift (lms_shift),
		.phe       (phe),
		.phe_valid (phe_valid),
		.dcw       (dcw),
		.dcw_valid (dcw_valid)
	);

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// gain x remainder, round half up, clip to code range
	function automatic logic [DCW_W-1:0] expected_dtc(input gain_t g, input logic [WF-1:0] r);
		longint p;
		longint code;
		p    = longint'(g) * longint'(r);
		code = (p + (longint'(1) << (2*WF-1))) >>> (2*WF);
		if (code > longint'(DTC_MAX)) begin
			code = longint'(DTC_MAX);
		end
		return DCW_W'(code);
	endfunction

	// error x remainder floored to WF bits, shifted, clamped at both rails
	function automatic gain_t lms_update(input gain_t g, input phe_t e,
		input logic [WF-1:0] r, input logic [3:0] sh);
		longint upd;
		longint nxt;
		upd = (longint'(e) * longint'(r)) >>> WF;
		upd = upd >>> sh;
		nxt = longint'(g) + upd;
		if (nxt < 0) begin
			nxt = 0;
		end else if (nxt > longint'(GAIN_MAX)) begin
			nxt = longint'(GAIN_MAX);
		end
		return gain_t'(nxt);
	endfunction

	// one clock edge of the model, inputs as sampled at that edge
	task automatic model_edge();
		exp_t e;
		int   sum;
		// execute edge of the word decoded one edge ago, old gain
		if (m_pend_valid) begin
			e.word.mmd = m_pend.mmd;
			e.word.rt  = m_pend.rt;
			e.word.dtc = expected_dtc(m_gain, m_pend.rem);
			e.due      = cyc + 2;
			exp_q.push_back(e);
		end
		if (!cal_en) begin
			m_gain = {kdtc_init, {WF{1'b0}}};
		end else if (phe_valid) begin
			m_gain = lms_update(m_gain, phe, m_rem_last, lms_shift);
		end
		if (m_pend_valid) begin
			m_rem_last = m_pend.rem;
		end
		// decode, fraction overflow is the carry
		m_pend_valid = step;
		if (step) begin
			sum        = int'(m_acc) + int'(fcw[WF-1:0]);
			m_acc      = WF'(sum % (1 << WF));
			m_pend.mmd = WI'(int'(fcw[WF +: WI]) + sum / (1 << WF));
			if (rt_en) begin
				m_pend.rt  = (int'(m_acc) >= (1 << (WF-1)));
				m_pend.rem = WF'(2 * (int'(m_acc) % (1 << (WF-1))));
			end else begin
				m_pend.rt  = 1'b0;
				m_pend.rem = m_acc;
			end
		end
	endtask

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic check_value(input string name, input longint got, input longint want);
		checks++;
		if (got != want) begin
			errors++;
			$display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
		end
	endtask

	// inputs change 2 ns after the edge
	task automatic tick();
		@(posedge CLK);
		#2;
	endtask

	task automatic do_step(input fcw_t f);
		fcw  = f;
		step = 1'b1;
		step_cnt++;
		tick();
		step = 1'b0;
	endtask

	// fraction tops the accumulator up to all ones, no carry
	task automatic step_full_residue();
		fcw_t f;
		f = {WI'(10), ~m_acc};
		do_step(f);
	endtask

	task automatic send_phe(input phe_t e);
		phe       = e;
		phe_valid = 1'b1;
		tick();
		phe_valid = 1'b0;
	endtask

	// integer 4 to 62 so int plus carry fits the mmd field
	function automatic fcw_t rand_fcw();
		int ip;
		ip = 4 + ({$random(seed)} % 59);
		return {WI'(ip), WF'($random(seed))};
	endfunction

	// sign < 0 negative, > 0 positive, 0 either
	function automatic phe_t rand_phe(input int sign);
		int mag;
		mag = {$random(seed)} % 32768;
		if (sign < 0) begin
			return phe_t'(-mag);
		end else if (sign > 0) begin
			return phe_t'(mag);
		end
		return phe_t'($random(seed));
	endfunction

	// load gain open loop, then step with a phase error two edges later
	task automatic lms_phase(input int k, input int sh, input int sign, input int n);
		cal_en    = 1'b0;
		kdtc_init = DCW_W'(k);
		lms_shift = 4'(sh);
		repeat (2) tick();
		cal_en = 1'b1;
		repeat (n) begin
			do_step(rand_fcw());
			// execute edge, no error pulse here
			tick();
			send_phe(rand_phe(sign));
		end
	endtask

	// ------------------------------------------------------------
	// clock, model edge and timeout
	// ------------------------------------------------------------
	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	initial begin
		forever begin
			@(posedge CLK);
			cyc = cyc + 1;
			if (cyc >= TIMEOUT_CYC) begin
				$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
				$display("FAIL: see errors above");
				$finish;
			end
			if (!NRST) begin
				m_acc        = '0;
				m_gain       = '0;
				m_rem_last   = '0;
				m_pend_valid = 1'b0;
				exp_q.delete();
			end else begin
				model_edge();
			end
		end
	end

	// ------------------------------------------------------------
	// compare, sampled mid cycle
	// ------------------------------------------------------------
	initial begin
		exp_t e;
		wait (NRST === 1'b1);
		forever begin
			@(negedge CLK);
			while (exp_q.size() > 0 && exp_q[0].due < cyc) begin
				e = exp_q.pop_front();
				errors++;
				$display("dcw_valid missing for the word due at cycle %0d", e.due);
			end
			if (dcw_valid) begin
				valid_cnt++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected dcw_valid at cycle %0d with no word pending", cyc);
				end else begin
					e = exp_q.pop_front();
					if (e.due != cyc) begin
						errors++;
						$display("dcw_valid at cycle %0d, word was due at cycle %0d", cyc, e.due);
					end
					check_value("dcw.mmd", longint'(dcw.mmd), longint'(e.word.mmd));
					check_value("dcw.rt", longint'(dcw.rt), longint'(e.word.rt));
					check_value("dcw.dtc", longint'(dcw.dtc), longint'(e.word.dtc));
				end
				last_dcw = dcw;
			end else begin
				// word holds between strobes
				check_value("dcw", longint'(dcw), longint'(last_dcw));
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		fcw_t f;
		NRST      = 1'b0;
		fcw       = '0;
		step      = 1'b0;
		rt_en     = 1'b0;
		kdtc_init = '0;
		cal_en    = 1'b0;
		lms_shift = '0;
		phe       = '0;
		phe_valid = 1'b0;
		repeat (8) @(posedge CLK);
		#2;
		NRST = 1'b1;
		repeat (2) tick();

		// reset values before any step
		check_value("dcw_valid", longint'(dcw_valid), 0);
		check_value("dcw.mmd", longint'(dcw.mmd), longint'(MMD_RESET));
		check_value("dcw.rt", longint'(dcw.rt), 0);
		check_value("dcw.dtc", longint'(dcw.dtc), 0);

		// modulus, back to back steps
		kdtc_init = 10'd300;
		repeat (4) begin
			f = rand_fcw();
			repeat (50) do_step(f);
		end
		repeat (4) tick();

		// retimer split
		rt_en = 1'b1;
		repeat (2) begin
			f = rand_fcw();
			repeat (50) do_step(f);
		end
		repeat (4) tick();
		rt_en = 1'b0;

		// fixed gains, zero up to full scale
		foreach (fixed_gain[i]) begin
			kdtc_init = DCW_W'(fixed_gain[i]);
			repeat (2) tick();
			repeat (30) do_step(rand_fcw());
		end
		repeat (4) tick();

		// lms, low rail, high rail, then both signs
		lms_phase(1, 0, -1, 20);
		lms_phase(1023, 0, 1, 20);
		// gain pushed to its rail, full residue rounds past 1023
		step_full_residue();
		tick();
		send_phe(16'sh7fff);
		send_phe(16'sh7fff);
		step_full_residue();
		repeat (2) tick();
		lms_phase(400, 3, 0, 50);
		cal_en = 1'b0;

		// random gaps between steps
		kdtc_init = 10'd700;
		rt_en     = 1'b1;
		repeat (60) begin
			do_step(rand_fcw());
			repeat ({$random(seed)} % 5) tick();
		end
		repeat (6) tick();

		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected words never appeared on dcw", exp_q.size());
		end
		check_value("dcw_valid count", longint'(valid_cnt), longint'(step_cnt));
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== hdl/dcw_align.sv ====
`timescale 1ns/100ps

module dcw_align import fod_pkg::*; (
	input  logic CLK,
	input  logic NRST,
	input  dcw_t exe_word,
	input  logic exe_valid,
	output dcw_t dcw,
	output logic dcw_valid
);

	// first output register
	dcw_t hold_word;
	logic hold_valid;

	// ------------------------------------------------------------
	// result register
	// ------------------------------------------------------------

	// mmd, rt and dtc captured as one word
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			hold_word  <= DCW_RESET;
			hold_valid <= 1'b0;
		end else begin
			hold_valid <= exe_valid;
			if (exe_valid) begin
				hold_word <= exe_word;
			end
		end
	end

	// ------------------------------------------------------------
	// output stage
	// ------------------------------------------------------------

	// extra cycle to top-level latency, holds between strobes
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			dcw       <= DCW_RESET;
			dcw_valid <= 1'b0;
		end else begin
			dcw_valid <= hold_valid;
			if (hold_valid) begin
				dcw <= hold_word;
			end
		end
	end

	// every output strobe traces back to an execute strobe
	a_valid_src: assert property (@(posedge CLK) disable iff (!NRST)
		dcw_valid |-> $past(exe_valid, 2));

endmodule

// ==== hdl/dsm_mash1.sv ====
`timescale 1ns/100ps

module dsm_mash1 import fod_pkg::*; (
	input  logic      CLK,
	input  logic      NRST,
	input  fcw_t      fcw,
	input  logic      step,
	input  logic      rt_en,
	output dsm_word_t dsm_word,
	output logic      dsm_valid
);

	// fcw split
	logic [WI-1:0] fcw_int;
	logic [WF-1:0] fcw_frac;
	// mash1 accumulator
	logic [WF-1:0] acc;
	logic [WF:0]   acc_sum;
	logic          carry;
	logic [WF-1:0] residue;

	assign fcw_int  = fcw[WF +: WI];
	assign fcw_frac = fcw[WF-1:0];

	// overflow of the fraction is the carry into the modulus
	assign acc_sum = {1'b0, acc} + {1'b0, fcw_frac};
	assign carry   = acc_sum[WF];
	assign residue = acc_sum[WF-1:0];

	// ------------------------------------------------------------
	// accumulator and strobe
	// ------------------------------------------------------------
	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			acc       <= '0;
			dsm_valid <= 1'b0;
		end else begin
			dsm_valid <= step;
			if (step) begin
				acc <= residue;
			end
		end
	end

	// ------------------------------------------------------------
	// word split
	// ------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (step) begin
			dsm_word.mmd <= fcw_int + WI'(carry);
			if (rt_en) begin
				// msb picks the retimer edge, rest doubled to full scale
				dsm_word.rt  <= residue[WF-1];
				dsm_word.rem <= {residue[WF-2:0], 1'b0};
			end else begin
				dsm_word.rt  <= 1'b0;
				dsm_word.rem <= residue;
			end
		end
	end

	// mmd cannot divide below 4
	a_fcw_int_min: assert property (@(posedge CLK) disable iff (!NRST)
		step |-> (fcw_int >= WI'(4)));

endmodule

// ==== hdl/dtc_gain_cal.sv ====
`timescale 1ns/100ps

module dtc_gain_cal import fod_pkg::*; (
	input  logic             CLK,
	input  logic             NRST,
	input  dsm_word_t        dsm_word,
	input  logic             dsm_valid,
	input  logic             cal_en,
	input  logic [DCW_W-1:0] kdtc_init,
	input  logic [3:0]       lms_shift,
	input  phe_t             phe,
	input  logic             phe_valid,
	output dcw_t             exe_word,
	output logic             exe_valid
);

	// gain state
	gain_t                    gain;
	gain_t                    gain_sat;
	logic [WF-1:0]            rem_last;
	// lms update path
	logic signed [2*WF:0]     upd_prod;
	logic signed [WF:0]       upd_scaled;
	logic signed [WF:0]       lms_step;
	logic signed [GAIN_W+1:0] gain_next;
	// dtc product
	logic [GAIN_W+WF-1:0]     dtc_prod;
	logic [DCW_W:0]           dtc_rnd;
	logic [DCW_W-1:0]         dtc_code;

	// ------------------------------------------------------------
	// lms update
	// ------------------------------------------------------------

	// phe x remainder, 2*WF fraction bits
	assign upd_prod = phe * $signed({1'b0, rem_last});
	// drop WF lsbs, floor toward -inf
	assign upd_scaled = upd_prod[2*WF:WF];
	// loop gain
	assign lms_step = upd_scaled >>> lms_shift;

	// two guard bits, clamp both ends
	assign gain_next = $signed({2'b00, gain}) + lms_step;
	always_comb begin
		if (gain_next < 0) begin
			gain_sat = '0;
		end else if (gain_next > $signed({2'b00, GAIN_MAX})) begin
			gain_sat = GAIN_MAX;
		end else begin
			gain_sat = gain_next[GAIN_W-1:0];
		end
	end

	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			gain     <= '0;
			rem_last <= '0;
		end else begin
			// open loop, follow the programmed gain
			if (!cal_en) begin
				gain <= {kdtc_init, {WF{1'b0}}};
			end else if (phe_valid) begin
				gain <= gain_sat;
			end
			// remainder that the next phase error belongs to
			if (dsm_valid) begin
				rem_last <= dsm_word.rem;
			end
		end
	end

	// ------------------------------------------------------------
	// dtc code
	// ------------------------------------------------------------

	// gain x remainder, integer part at bit 2*WF
	assign dtc_prod = gain * dsm_word.rem;
	// round half up on first dropped bit
	assign dtc_rnd  = {1'b0, dtc_prod[2*WF +: DCW_W]} + (DCW_W+1)'(dtc_prod[2*WF-1]);
	assign dtc_code = dtc_rnd[DCW_W] ? DTC_MAX : dtc_rnd[DCW_W-1:0];

	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= dsm_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (dsm_valid) begin
			exe_word.mmd <= dsm_word.mmd;
			exe_word.rt  <= dsm_word.rt;
			exe_word.dtc <= dtc_code;
		end
	end

	// gain moves in the direction of the update, never wraps past a rail
	a_gain_no_wrap: assert property (@(posedge CLK) disable iff (!NRST)
		(cal_en && phe_valid) |=>
		(($past(lms_step) < 0) ? (gain <= $past(gain)) : (gain >= $past(gain))));

endmodule

// ==== hdl/fod_ctrl.sv ====
`timescale 1ns/100ps

module fod_ctrl import fod_pkg::*; (
	input  logic             CLK,
	input  logic             NRST,
	input  fcw_t             fcw,
	input  logic             step,
	input  logic             rt_en,
	input  logic [DCW_W-1:0] kdtc_init,
	input  logic             cal_en,
	input  logic [3:0]       lms_shift,
	input  phe_t             phe,
	input  logic             phe_valid,
	output dcw_t             dcw,
	output logic             dcw_valid
);

	// decode to execute
	dsm_word_t dsm_word;
	logic      dsm_valid;
	// execute to result
	dcw_t      exe_word;
	logic      exe_valid;

	// mash1, modulus and residue split
	dsm_mash1 u_dsm (
		.CLK       (CLK),
		.NRST      (NRST),
		.fcw       (fcw),
		.step      (step),
		.rt_en     (rt_en),
		.dsm_word  (dsm_word),
		.dsm_valid (dsm_valid)
	);

	// gain lms and dtc code
	dtc_gain_cal u_gain (
		.CLK       (CLK),
		.NRST      (NRST),
		.dsm_word  (dsm_word),
		.dsm_valid (dsm_valid),
		.cal_en    (cal_en),
		.kdtc_init (kdtc_init),
		.lms_shift (lms_shift),
		.phe       (phe),
		.phe_valid (phe_valid),
		.exe_word  (exe_word),
		.exe_valid (exe_valid)
	);

	// aligned outputs
	dcw_align u_align (
		.CLK       (CLK),
		.NRST      (NRST),
		.exe_word  (exe_word),
		.exe_valid (exe_valid),
		.dcw       (dcw),
		.dcw_valid (dcw_valid)
	);

endmodule

// ==== hdl/fod_pkg.sv ====
package fod_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------

	// fcw integer bits, mmd range 4 to 63
	localparam int WI = 6;
	// fcw and phase fractional bits
	localparam int WF = 16;
	// dtc code width
	localparam int DCW_W = 10;
	// gain register, DCW_W integer plus WF fraction
	localparam int GAIN_W = DCW_W + WF;

	// ------------------------------------------------------------
	// constants
	// ------------------------------------------------------------

	// modulus shown out of reset
	localparam int MMD_RESET = 4;
	// largest dtc code
	localparam logic [DCW_W-1:0] DTC_MAX = '1;

	// ------------------------------------------------------------
	// fixed-point types
	// ------------------------------------------------------------

	// ufix, WI.WF
	typedef logic [WI+WF-1:0] fcw_t;
	// sfix, -0.5 to 0.5
	typedef logic signed [WF-1:0] phe_t;
	// ufix, DCW_W.WF
	typedef logic [GAIN_W-1:0] gain_t;

	// gain ceiling for saturation
	localparam gain_t GAIN_MAX = '1;

	// decode stage output, one per divider period
	typedef struct packed {
		logic [WI-1:0] mmd;
		// retimer select
		logic          rt;
		// ufix 0 <= x < 1
		logic [WF-1:0] rem;
	} dsm_word_t;

	// divider control words
	typedef struct packed {
		logic [WI-1:0]    mmd;
		logic             rt;
		logic [DCW_W-1:0] dtc;
	} dcw_t;

	// output word after reset
	localparam dcw_t DCW_RESET = '{mmd: WI'(MMD_RESET), rt: 1'b0, dtc: '0};

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run fod_ctrl_tb with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=fod_ctrl_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module fod_ctrl_tb -o "$bin" -f verilog.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/"$bin" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
	echo "simulation reported errors"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== verilog.f ====
hdl/fod_pkg.sv
hdl/dsm_mash1.sv
hdl/dtc_gain_cal.sv
hdl/dcw_align.sv
hdl/fod_ctrl.sv
dv/fod_ctrl_tb.sv
